// ==== hdl/median_pkg.sv ====
package median_pkg;

    localparam int PIX_W       = 8;
    localparam int DATA_W      = 32;
    localparam int DIM_W       = 10;
    localparam int IMG_ADDR_W  = 12;
    localparam int MODE_W      = 2;
    localparam int WIN_TAPS    = 9;
    localparam int MEDIAN_TAP  = 4;
    localparam int SORT_PASSES = 9;
    localparam int TAP_W       = 4;
    localparam int PASS_W      = $clog2(SORT_PASSES);
    localparam int IMG_DEPTH   = 1 << IMG_ADDR_W;

    typedef logic [PIX_W-1:0]      pixel_t;
    typedef logic [DIM_W-1:0]      dim_t;
    typedef logic [IMG_ADDR_W-1:0] img_addr_t;

    // Top bits of the host address
    typedef enum logic [MODE_W-1:0] {
        MODE_PIXEL  = 2'd0,
        MODE_START  = 2'd1,  // Reads back as status
        MODE_WIDTH  = 2'd2,
        MODE_HEIGHT = 2'd3
    } host_mode_e;

    typedef struct packed {
        logic              en;
        logic              we;
        host_mode_e        mode;
        img_addr_t         addr;
        logic [DATA_W-1:0] wdata;
    } host_req_t;

    typedef struct packed {
        logic      en;
        logic      we;
        img_addr_t addr;
        pixel_t    wdata;
    } ram_port_t;

    typedef struct packed {
        logic             load;
        logic [TAP_W-1:0] idx;
        logic             pad;  // Tap lies outside the image
    } tap_t;

    typedef pixel_t [WIN_TAPS-1:0] window_t;

endpackage

// ==== hdl/pixel_ram.sv ====
`timescale 1ns/1ns

module pixel_ram (
    input  logic                  CLK,
    input  median_pkg::ram_port_t port_i,
    output median_pkg::pixel_t    rdata_o
);
    import median_pkg::*;

    pixel_t mem [IMG_DEPTH];

    always_ff @(posedge CLK) begin
        if (port_i.en) begin
            if (port_i.we) begin
                mem[port_i.addr] <= port_i.wdata;
            end else begin
                rdata_o <= mem[port_i.addr];  // One cycle read latency
            end
        end
    end

    a_addr_in_range: assert property (
        @(posedge CLK) port_i.en |-> !$isunknown(port_i.addr) && (port_i.addr < IMG_DEPTH)
    ) else $error("pixel_ram address %h out of range", port_i.addr);

endmodule

// ==== hdl/median_regs.sv ====
`timescale 1ns/1ns

module median_regs (
    input  logic                  CLK,
    input  logic                  RST,
    input  median_pkg::host_req_t req_i,
    input  logic                  busy_i,
    input  logic                  done_i,
    input  median_pkg::ram_port_t eng_in_port_i,
    input  median_pkg::ram_port_t eng_out_port_i,
    input  median_pkg::tap_t      tap_i,
    input  median_pkg::pixel_t    out_rdata_i,
    output median_pkg::ram_port_t in_port_o,
    output median_pkg::ram_port_t out_port_o,
    output median_pkg::tap_t      tap_o,
    output logic                  start_o,
    output median_pkg::dim_t      width_o,
    output median_pkg::dim_t      height_o,
    output logic [median_pkg::DATA_W-1:0] rdata_o
);
    import median_pkg::*;

    host_mode_e rd_mode_q;
    tap_t       tap_q;
    logic       pix_wr;
    logic       pix_rd;

    assign pix_wr = req_i.en && req_i.we && (req_i.mode == MODE_PIXEL);
    assign pix_rd = req_i.en && !req_i.we && (req_i.mode == MODE_PIXEL);

    always_ff @(posedge CLK or negedge RST) begin
        if (!RST) begin
            start_o   <= 1'b0;
            width_o   <= '0;
            height_o  <= '0;
            rd_mode_q <= MODE_PIXEL;
            tap_q     <= '0;
        end else begin
            tap_q <= tap_i;  // Lines up with the memory read latency
            if (req_i.en && req_i.we) begin
                case (req_i.mode)
                    MODE_START:  start_o  <= req_i.wdata[0];
                    MODE_WIDTH:  width_o  <= req_i.wdata[DIM_W-1:0];
                    MODE_HEIGHT: height_o <= req_i.wdata[DIM_W-1:0];
                    default: ;
                endcase
            end
            if (req_i.en && !req_i.we) begin
                rd_mode_q <= req_i.mode;
            end
        end
    end

    assign tap_o = tap_q;

    // Engine owns both memories while busy
    always_comb begin
        if (busy_i) begin
            in_port_o  = eng_in_port_i;
            out_port_o = eng_out_port_i;
        end else begin
            in_port_o.en     = pix_wr;
            in_port_o.we     = 1'b1;
            in_port_o.addr   = req_i.addr;
            in_port_o.wdata  = req_i.wdata[PIX_W-1:0];
            out_port_o.en    = pix_rd;
            out_port_o.we    = 1'b0;
            out_port_o.addr  = req_i.addr;
            out_port_o.wdata = '0;
        end
    end

    always_comb begin
        rdata_o = '0;
        case (rd_mode_q)
            MODE_PIXEL: if (done_i) rdata_o[PIX_W-1:0] = out_rdata_i;
            MODE_START: rdata_o[0] = done_i;
            default: ;  // Width and height are write only
        endcase
    end

endmodule

// ==== hdl/median_ctrl.sv ====
`timescale 1ns/1ns

module median_ctrl (
    input  logic                  CLK,
    input  logic                  RST,
    input  logic                  start_i,
    input  median_pkg::dim_t      width_i,
    input  median_pkg::dim_t      height_i,
    input  median_pkg::pixel_t    median_i,
    input  logic                  median_valid_i,
    output logic                  busy_o,
    output logic                  done_o,
    output median_pkg::ram_port_t in_port_o,
    output median_pkg::ram_port_t out_port_o,
    output median_pkg::tap_t      tap_o,
    output logic                  sort_start_o
);
    import median_pkg::*;

    typedef enum logic [1:0] {ST_IDLE, ST_LOAD, ST_SORT, ST_DONE} state_e;

    state_e           state_q;
    dim_t             row_q;
    dim_t             col_q;
    logic [TAP_W-1:0] tap_q;
    img_addr_t        row_base_q;
    logic             sort_start_q;

    logic [1:0]       tap_row;
    logic [1:0]       tap_col;
    img_addr_t        row_addr;
    img_addr_t        tap_addr;
    logic             last_col;
    logic             last_row;
    logic             pad;

    assign last_col = (col_q == dim_t'(width_i - 1'b1));
    assign last_row = (row_q == dim_t'(height_i - 1'b1));

    always_ff @(posedge CLK or negedge RST) begin
        if (!RST) begin
            state_q      <= ST_IDLE;
            row_q        <= '0;
            col_q        <= '0;
            tap_q        <= '0;
            row_base_q   <= '0;
            sort_start_q <= 1'b0;
        end else begin
            sort_start_q <= 1'b0;
            case (state_q)
                ST_IDLE: begin
                    row_q      <= '0;
                    col_q      <= '0;
                    tap_q      <= '0;
                    row_base_q <= '0;
                    if (start_i) begin
                        state_q <= ST_LOAD;
                    end
                end
                ST_LOAD: begin
                    tap_q <= tap_q + 1'b1;
                    if (tap_q == TAP_W'(WIN_TAPS - 1)) begin
                        state_q <= ST_SORT;
                    end
                end
                ST_SORT: begin
                    // Last tap lands in the window during this cycle
                    if (tap_q == TAP_W'(WIN_TAPS)) begin
                        tap_q        <= tap_q + 1'b1;
                        sort_start_q <= 1'b1;
                    end
                    if (median_valid_i) begin
                        tap_q <= '0;
                        if (last_col) begin
                            col_q      <= '0;
                            row_q      <= row_q + 1'b1;
                            row_base_q <= row_base_q + width_i;
                            state_q    <= last_row ? ST_DONE : ST_LOAD;
                        end else begin
                            col_q   <= col_q + 1'b1;
                            state_q <= ST_LOAD;
                        end
                    end
                end
                ST_DONE: begin
                    if (!start_i) begin
                        state_q <= ST_IDLE;
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    // Tap address and border flags
    always_comb begin
        tap_row = 2'(tap_q / 3);
        tap_col = 2'(tap_q % 3);
        case (tap_row)
            2'd0:    row_addr = row_base_q - width_i;
            2'd1:    row_addr = row_base_q;
            default: row_addr = row_base_q + width_i;
        endcase
        tap_addr = img_addr_t'(row_addr + col_q + tap_col - 1);
        pad = (tap_row == 2'd0 && row_q == '0) || (tap_row == 2'd2 && last_row) ||
              (tap_col == 2'd0 && col_q == '0) || (tap_col == 2'd2 && last_col);
    end

    assign busy_o       = (state_q == ST_LOAD) || (state_q == ST_SORT);
    assign done_o       = (state_q == ST_DONE);
    assign sort_start_o = sort_start_q;

    always_comb begin
        in_port_o.en     = (state_q == ST_LOAD);
        in_port_o.we     = 1'b0;
        in_port_o.addr   = tap_addr;
        in_port_o.wdata  = '0;
        out_port_o.en    = median_valid_i && (state_q == ST_SORT);
        out_port_o.we    = median_valid_i && (state_q == ST_SORT);
        out_port_o.addr  = img_addr_t'(row_base_q + col_q);
        out_port_o.wdata = median_i;
        tap_o.load       = (state_q == ST_LOAD);
        tap_o.idx        = tap_q;
        tap_o.pad        = pad;
    end

    a_sort_start_in_sort: assert property (
        @(posedge CLK) disable iff (!RST) sort_start_o |-> (state_q == ST_SORT)
    ) else $error("sort_start outside the sort state");

endmodule

// ==== hdl/median_window.sv ====
`timescale 1ns/1ns

module median_window (
    input  logic                CLK,
    input  logic                RST,
    input  median_pkg::pixel_t  rdata_i,
    input  median_pkg::tap_t    tap_i,
    output median_pkg::window_t window_o
);
    import median_pkg::*;

    window_t win_q;

    always_ff @(posedge CLK or negedge RST) begin
        if (!RST) begin
            win_q <= '0;
        end else if (tap_i.load) begin
            win_q[tap_i.idx] <= tap_i.pad ? '0 : rdata_i;  // Outside pixels count as zero
        end
    end

    assign window_o = win_q;

    a_tap_idx_range: assert property (
        @(posedge CLK) disable iff (!RST) tap_i.load |-> (tap_i.idx < WIN_TAPS)
    ) else $error("window tap index %0d out of range", tap_i.idx);

endmodule

// ==== hdl/median_sorter.sv ====
`timescale 1ns/1ns

module median_sorter (
    input  logic                CLK,
    input  logic                RST,
    input  logic                start_i,
    input  median_pkg::window_t window_i,
    output median_pkg::pixel_t  median_o,
    output logic                valid_o
);
    import median_pkg::*;

    logic              running;
    logic [PASS_W-1:0] pass_cnt;
    window_t           sort_q;
    window_t           pass_out;

    always_ff @(posedge CLK or negedge RST) begin
        if (!RST) begin
            running  <= 1'b0;
            pass_cnt <= '0;
            valid_o  <= 1'b0;
        end else begin
            valid_o <= 1'b0;
            if (!running) begin
                if (start_i) begin
                    running  <= 1'b1;
                    pass_cnt <= '0;
                end
            end else if (pass_cnt == PASS_W'(SORT_PASSES - 1)) begin
                running <= 1'b0;
                valid_o <= 1'b1;
            end else begin
                pass_cnt <= pass_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (!running && start_i) begin
            sort_q <= window_i;
        end else if (running) begin
            sort_q <= pass_out;
        end
    end

    // Even passes pair (0,1),(2,3).. and odd passes pair (1,2),(3,4)..
    always_comb begin
        pass_out = sort_q;
        for (int k = 0; k < WIN_TAPS - 1; k++) begin
            if ((k % 2) == pass_cnt[0] && sort_q[k] > sort_q[k+1]) begin
                pass_out[k]   = sort_q[k+1];
                pass_out[k+1] = sort_q[k];
            end
        end
    end

    assign median_o = sort_q[MEDIAN_TAP];

    a_no_start_while_running: assert property (
        @(posedge CLK) disable iff (!RST) running |-> !start_i
    ) else $error("sort start ignored while a sort is running");

endmodule

// ==== hdl/median_filter_unit.sv ====
`timescale 1ns/1ns

module median_filter_unit (
    input  logic                                          CLK,
    input  logic                                          RST,
    input  logic                                          ena_i,
    input  logic                                          wea_i,
    input  logic [median_pkg::MODE_W+median_pkg::IMG_ADDR_W-1:0] addra_i,
    input  logic [median_pkg::DATA_W-1:0]                 dina_i,
    output logic [median_pkg::DATA_W-1:0]                 douta_o
);
    import median_pkg::*;

    host_req_t host_req;
    ram_port_t eng_in_port;
    ram_port_t eng_out_port;
    ram_port_t in_port;
    ram_port_t out_port;
    tap_t      eng_tap;
    tap_t      win_tap;
    pixel_t    in_rdata;
    pixel_t    out_rdata;
    pixel_t    median;
    window_t   window;
    dim_t      width;
    dim_t      height;
    logic      start;
    logic      busy;
    logic      done;
    logic      sort_start;
    logic      median_valid;

    assign host_req = '{
        en:    ena_i,
        we:    wea_i,
        mode:  host_mode_e'(addra_i[MODE_W+IMG_ADDR_W-1:IMG_ADDR_W]),
        addr:  addra_i[IMG_ADDR_W-1:0],
        wdata: dina_i
    };

    median_regs i_median_regs (
        .CLK(CLK), .RST(RST), .req_i(host_req), .busy_i(busy), .done_i(done),
        .eng_in_port_i(eng_in_port), .eng_out_port_i(eng_out_port), .tap_i(eng_tap),
        .out_rdata_i(out_rdata), .in_port_o(in_port), .out_port_o(out_port),
        .tap_o(win_tap), .start_o(start), .width_o(width), .height_o(height),
        .rdata_o(douta_o)
    );

    median_ctrl i_median_ctrl (
        .CLK(CLK), .RST(RST), .start_i(start), .width_i(width), .height_i(height),
        .median_i(median), .median_valid_i(median_valid), .busy_o(busy), .done_o(done),
        .in_port_o(eng_in_port), .out_port_o(eng_out_port), .tap_o(eng_tap),
        .sort_start_o(sort_start)
    );

    median_window i_median_window (
        .CLK(CLK), .RST(RST), .rdata_i(in_rdata), .tap_i(win_tap), .window_o(window)
    );

    median_sorter i_median_sorter (
        .CLK(CLK), .RST(RST), .start_i(sort_start), .window_i(window),
        .median_o(median), .valid_o(median_valid)
    );

    pixel_ram i_in_ram (.CLK(CLK), .port_i(in_port), .rdata_o(in_rdata));

    pixel_ram i_out_ram (.CLK(CLK), .port_i(out_port), .rdata_o(out_rdata));

endmodule

// ==== bench/median_checker.sv ====
`timescale 1ns/1ns

module median_checker (
    input  logic                                                 CLK,
    input  logic                                                 RST,
    input  logic                                                 ena_i,
    input  logic                                                 wea_i,
    input  logic [median_pkg::MODE_W+median_pkg::IMG_ADDR_W-1:0] addra_i,
    input  logic [median_pkg::DATA_W-1:0]                        dina_i,
    input  logic [median_pkg::DATA_W-1:0]                        douta_i,
    output int                                                   err_cnt_o,
    output int                                                   chk_cnt_o
);
    import median_pkg::*;

    pixel_t     img [IMG_DEPTH];  // Input image as the host wrote it
    int         width;
    int         height;
    int         run_cyc;  // Cycles since the start write
    logic       start_q;
    logic       done_seen;
    logic       rd_pend;
    host_mode_e rd_mode;
    img_addr_t  rd_addr;

    // Median of the 3x3 neighbourhood, outside pixels count as zero
    function automatic pixel_t ref_median(input int r, input int c);
        pixel_t win [9];
        pixel_t med;
        int     n;
        int     lt;
        int     le;
        n = 0;
        med = '0;
        for (int dr = -1; dr <= 1; dr++) begin
            for (int dc = -1; dc <= 1; dc++) begin
                if (r + dr < 0 || r + dr >= height || c + dc < 0 || c + dc >= width) begin
                    win[n] = '0;
                end else begin
                    win[n] = img[(r + dr) * width + c + dc];
                end
                n++;
            end
        end
        for (int i = 0; i < 9; i++) begin
            lt = 0;
            le = 0;
            for (int k = 0; k < 9; k++) begin
                if (win[k] < win[i]) lt++;
                if (win[k] <= win[i]) le++;
            end
            if (lt <= 4 && le > 4) med = win[i];  // Fifth smallest
        end
        return med;
    endfunction

    task automatic check_read(input host_mode_e mode, input img_addr_t addr,
                              input logic [DATA_W-1:0] got);
        logic [DATA_W-1:0] exp;
        int                npix;
        exp = '0;
        npix = width * height;
        case (mode)
            MODE_PIXEL: if (done_seen) exp = DATA_W'(ref_median(addr / width, addr % width));
            MODE_START: begin
                // Done is due between 18 and 25 cycles per pixel after start
                if (start_q && (done_seen || run_cyc >= 25 * npix)) begin
                    exp = 1;
                end else if (start_q && run_cyc >= 18 * npix && got === 1) begin
                    exp = 1;  // Either level is legal inside this window
                end
                done_seen = exp[0];
            end
            default: ;
        endcase
        chk_cnt_o++;
        if (got !== exp) begin
            err_cnt_o++;
            $display("MISMATCH douta_o mode %0d addr %h: got %h expected %h",
                     mode, addr, got, exp);
        end
    endtask

    always @(negedge CLK) begin
        if (!RST) begin
            err_cnt_o = 0;
            chk_cnt_o = 0;
            width     = 0;
            height    = 0;
            run_cyc   = 0;
            start_q   = 1'b0;
            done_seen = 1'b0;
            rd_pend   = 1'b0;
        end else begin
            if (start_q) run_cyc++;
            if (rd_pend) check_read(rd_mode, rd_addr, douta_i);
            rd_pend = 1'b0;
            if (ena_i && wea_i) begin
                case (host_mode_e'(addra_i[MODE_W+IMG_ADDR_W-1:IMG_ADDR_W]))
                    MODE_PIXEL:  if (!start_q) img[addra_i[IMG_ADDR_W-1:0]] = dina_i[PIX_W-1:0];
                    MODE_START: begin
                        start_q = dina_i[0];
                        run_cyc = 0;
                        if (!dina_i[0]) done_seen = 1'b0;
                    end
                    MODE_WIDTH:  width = dina_i[DIM_W-1:0];
                    MODE_HEIGHT: height = dina_i[DIM_W-1:0];
                endcase
            end else if (ena_i) begin
                rd_pend = 1'b1;
                rd_mode = host_mode_e'(addra_i[MODE_W+IMG_ADDR_W-1:IMG_ADDR_W]);
                rd_addr = addra_i[IMG_ADDR_W-1:0];
            end
        end
    end

endmodule

// ==== bench/tb_median_filter.sv ====
`timescale 1ns/1ns

module tb_median_filter;
    import median_pkg::*;

    localparam int         CLK_PERIOD = 40;
    localparam int         NUM_CASES  = 6;
    localparam logic [1:0] PAT_RAMP   = 2'd0;
    localparam logic [1:0] PAT_CONST  = 2'd1;
    localparam logic [1:0] PAT_LCG    = 2'd2;

    typedef struct packed {
        dim_t       width;
        dim_t       height;
        logic [1:0] kind;
        pixel_t     value;  // Constant level or ramp offset
    } case_t;

    localparam case_t CASES [NUM_CASES] = '{
        '{10'd8, 10'd6, PAT_LCG,   8'd0},
        '{10'd5, 10'd4, PAT_RAMP,  8'd3},
        '{10'd1, 10'd1, PAT_CONST, 8'd77},
        '{10'd1, 10'd7, PAT_RAMP,  8'd40},
        '{10'd6, 10'd5, PAT_CONST, 8'd200},
        '{10'd7, 10'd3, PAT_LCG,   8'd0}
    };

    logic                         CLK;
    logic                         RST;
    logic                         ena;
    logic                         wea;
    logic [MODE_W+IMG_ADDR_W-1:0] addra;
    logic [DATA_W-1:0]            dina;
    logic [DATA_W-1:0]            douta;
    logic [31:0]                  lcg_state;
    int                           checker_errs;
    int                           checks;
    int                           pass_cnt;
    int                           fail_cnt;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic pixel_t pattern_pixel(input case_t tc, input int idx);
        pixel_t p;
        case (tc.kind)
            PAT_RAMP:  p = pixel_t'(idx * 11 + tc.value);
            PAT_CONST: p = tc.value;
            default: begin
                lcg_state = lcg_next(lcg_state);
                p = lcg_state[23:16];
            end
        endcase
        return p;
    endfunction

    task automatic host_write(input host_mode_e mode, input img_addr_t addr,
                              input logic [DATA_W-1:0] data);
        @(posedge CLK);
        ena   <= 1'b1;
        wea   <= 1'b1;
        addra <= {mode, addr};
        dina  <= data;
        @(posedge CLK);
        ena <= 1'b0;
        wea <= 1'b0;
    endtask

    task automatic host_read(input host_mode_e mode, input img_addr_t addr,
                             output logic [DATA_W-1:0] data);
        @(posedge CLK);
        ena   <= 1'b1;
        wea   <= 1'b0;
        addra <= {mode, addr};
        @(posedge CLK);
        ena <= 1'b0;
        @(negedge CLK);
        data = douta;  // Valid one cycle after the strobe
    endtask

    task automatic report_test(input string name, input int errs);
        $display("%s: %s (%0d errors)", name, (errs == 0) ? "pass" : "FAIL", errs);
        if (errs == 0) pass_cnt++;
        else fail_cnt++;
    endtask

    task automatic run_case(input int num, input case_t tc);
        logic [DATA_W-1:0] rd;
        int                n;
        int                polls;
        int                errs;
        n = tc.width * tc.height;
        errs = checker_errs;
        host_write(MODE_WIDTH, '0, DATA_W'(tc.width));
        host_write(MODE_HEIGHT, '0, DATA_W'(tc.height));
        // Width and height are write only
        host_read(MODE_WIDTH, '0, rd);
        host_read(MODE_HEIGHT, '0, rd);
        for (int i = 0; i < n; i++) host_write(MODE_PIXEL, img_addr_t'(i), pattern_pixel(tc, i));
        host_write(MODE_START, '0, 1);
        // Engine is busy now, so these must not reach the input image
        for (int i = 0; i < 3; i++) host_write(MODE_PIXEL, img_addr_t'(i), 32'hff);
        rd = '0;
        polls = 0;
        while (rd[0] !== 1'b1 && polls < (25 * n + 2000) / 2) begin
            host_read(MODE_START, '0, rd);
            polls++;
        end
        if (rd[0] !== 1'b1) begin
            errs--;
            $display("case %0d: engine never reported done", num);
        end else begin
            for (int i = 0; i < n; i++) host_read(MODE_PIXEL, img_addr_t'(i), rd);
        end
        host_write(MODE_START, '0, 0);
        host_read(MODE_START, '0, rd);
        @(posedge CLK);
        report_test($sformatf("case %0d %0dx%0d", num, tc.width, tc.height),
                    checker_errs - errs);
    endtask

    task automatic idle_reads();
        logic [DATA_W-1:0] rd;
        int                errs;
        errs = checker_errs;
        host_read(MODE_START, '0, rd);
        for (int i = 0; i < 16; i++) host_read(MODE_PIXEL, img_addr_t'(i), rd);
        @(posedge CLK);
        report_test("idle reads", checker_errs - errs);
    endtask

    median_filter_unit i_median_filter_unit (
        .CLK(CLK), .RST(RST), .ena_i(ena), .wea_i(wea), .addra_i(addra),
        .dina_i(dina), .douta_o(douta)
    );

    median_checker i_median_checker (
        .CLK(CLK), .RST(RST), .ena_i(ena), .wea_i(wea), .addra_i(addra),
        .dina_i(dina), .douta_i(douta), .err_cnt_o(checker_errs), .chk_cnt_o(checks)
    );

    initial begin
        CLK = 1'b0;
        forever #(CLK_PERIOD / 2) CLK = ~CLK;
    end

    // Watchdog sized from the case table
    initial begin
        int limit;
        limit = 500;
        for (int i = 0; i < NUM_CASES; i++) begin
            limit += 25 * CASES[i].width * CASES[i].height + 2000;
        end
        repeat (limit) @(posedge CLK);
        $display("Watchdog expired after %0d cycles", limit);
        $display("Test FAILED");
        $finish;
    end

    initial begin
        RST       = 1'b0;
        ena       = 1'b0;
        wea       = 1'b0;
        addra     = '0;
        dina      = '0;
        lcg_state = 32'h4d27;
        pass_cnt  = 0;
        fail_cnt  = 0;
        repeat (3) @(posedge CLK);
        RST <= 1'b1;
        idle_reads();
        for (int i = 0; i < NUM_CASES; i++) run_case(i, CASES[i]);
        $display("%0d passed, %0d failed, %0d reads checked", pass_cnt, fail_cnt, checks);
        if (fail_cnt == 0 && checker_errs == 0 && checks > 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// ==== sources.f ====
hdl/median_pkg.sv
hdl/pixel_ram.sv
hdl/median_regs.sv
hdl/median_ctrl.sv
hdl/median_window.sv
hdl/median_sorter.sv
hdl/median_filter_unit.sv
bench/median_checker.sv
bench/tb_median_filter.sv

// ==== Bender.yml ====
package:
  name: median_filter

sources:
  - files:
      - hdl/median_pkg.sv
      - hdl/pixel_ram.sv
      - hdl/median_regs.sv
      - hdl/median_ctrl.sv
      - hdl/median_window.sv
      - hdl/median_sorter.sv
      - hdl/median_filter_unit.sv
  - target: simulation
    files:
      - bench/median_checker.sv
      - bench/tb_median_filter.sv
